// ==== verilog/core_pkg.sv ====
package core_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 4;

	localparam logic [4:0] OPC_LUI   = 5'b01101;
	localparam logic [4:0] OPC_AUIPC = 5'b00101;
	localparam logic [4:0] OPC_ADDI  = 5'b00100;
	localparam logic [4:0] OPC_ADD   = 5'b01100;
	localparam logic [4:0] OPC_LW    = 5'b00000;
	localparam logic [4:0] OPC_SW    = 5'b01000;

	typedef enum logic [2:0] {
		OP_NOP,
		OP_LUI,
		OP_AUIPC,
		OP_ADDI,
		OP_ADD,
		OP_LW,
		OP_SW
	} op_class_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		u_fmt_t u;
	} inst_u;

endpackage

// ==== verilog/pipe_ifs.sv ====
`timescale 1ns/1ns

interface ex_bus_if import core_pkg::*; ();
	logic              valid;
	op_class_e         op;
	logic [REG_AW-1:0] rd;
	logic              reg_wen;
	logic [XLEN-1:0]   src1;
	logic [XLEN-1:0]   src2;
	logic [XLEN-1:0]   imm;
	logic [XLEN-1:0]   pc;

	modport source (output valid, op, rd, reg_wen, src1, src2, imm, pc);
	modport sink   (input  valid, op, rd, reg_wen, src1, src2, imm, pc);
endinterface

interface mem_bus_if import core_pkg::*; ();
	logic              valid;
	logic              is_load;
	logic              is_store;
	logic [REG_AW-1:0] rd;
	logic              reg_wen;
	logic [XLEN-1:0]   result; // alu value, or the address for loads and stores.
	logic [XLEN-1:0]   store_data;

	modport source (output valid, is_load, is_store, rd, reg_wen, result, store_data);
	modport sink   (input  valid, is_load, is_store, rd, reg_wen, result, store_data);
endinterface

interface bypass_if import core_pkg::*; ();
	logic              valid;
	logic [REG_AW-1:0] rd;
	logic              reg_wen;
	logic              is_load;
	logic [XLEN-1:0]   value;

	modport source (output valid, rd, reg_wen, is_load, value);
	modport sink   (input  valid, rd, reg_wen, is_load, value);
endinterface

// ==== verilog/inst_queue.sv ====
`timescale 1ns/1ns

module inst_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        inst_valid,
	input  logic [31:0] inst,
	output logic        head_valid,
	output logic [31:0] head_inst,
	input  logic        pop,
	output logic        inst_credit
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(QUEUE_DEPTH - 1);

	logic [31:0]      entries [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign head_valid = (count != '0);
	assign head_inst  = entries[rd_ptr];

	always_ff @(posedge clock) begin
		if (inst_valid) begin
			entries[wr_ptr] <= inst; // the sender's credits keep this slot free.
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			inst_credit <= 1'b0;
		end else begin
			if (inst_valid) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			case ({inst_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			inst_credit <= pop; // one credit back per popped entry.
		end
	end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage import core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic              clock,
	input  logic              arst_n,
	input  logic              head_valid,
	input  logic [31:0]       head_inst,
	output logic              pop,
	output logic [REG_AW-1:0] rs1,
	output logic [REG_AW-1:0] rs2,
	input  logic [XLEN-1:0]   rdata1,
	input  logic [XLEN-1:0]   rdata2,
	ex_bus_if.source          ex,
	bypass_if.sink            m_byp,
	bypass_if.sink            w_byp
);

	inst_u             iw;
	op_class_e         cls;
	logic [XLEN-1:0]   imm;
	logic [REG_AW-1:0] rd;
	logic              reg_wen;
	logic              need_rs1;
	logic              need_rs2;
	logic              rs1_ex_hit;
	logic              rs2_ex_hit;
	logic              rs1_m_hit;
	logic              rs2_m_hit;
	logic              rs1_w_hit;
	logic              rs2_w_hit;
	logic              stall;
	logic [XLEN-1:0]   src1;
	logic [XLEN-1:0]   src2;
	logic [XLEN-1:0]   pc;

	function automatic logic src_hit(
		input logic              valid,
		input logic              wen,
		input logic [REG_AW-1:0] dst,
		input logic [REG_AW-1:0] src
	);
		return valid & wen & (dst != '0) & (dst == src);
	endfunction

	assign iw  = head_inst;
	assign rs1 = iw.r.rs1[REG_AW-1:0]; // rv32e only has sixteen registers.
	assign rs2 = iw.r.rs2[REG_AW-1:0];
	assign rd  = iw.r.rd[REG_AW-1:0];

	always_comb begin
		cls = OP_NOP;
		imm = '0;
		case (iw.r.opcode[6:2])
			OPC_LUI: begin
				cls = OP_LUI;
				imm = {iw.u.imm, 12'b0};
			end
			OPC_AUIPC: begin
				cls = OP_AUIPC;
				imm = {iw.u.imm, 12'b0};
			end
			OPC_ADDI: begin
				cls = OP_ADDI;
				imm = {{20{iw.i.imm[11]}}, iw.i.imm};
			end
			OPC_ADD: begin
				cls = OP_ADD;
			end
			OPC_LW: begin
				cls = OP_LW;
				imm = {{20{iw.i.imm[11]}}, iw.i.imm};
			end
			OPC_SW: begin
				cls = OP_SW;
				imm = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
			end
			default: begin
				cls = OP_NOP; // anything else moves down the pipe as a bubble.
			end
		endcase
	end

	assign reg_wen  = cls inside {OP_LUI, OP_AUIPC, OP_ADDI, OP_ADD, OP_LW};
	assign need_rs1 = cls inside {OP_ADDI, OP_ADD, OP_LW, OP_SW};
	assign need_rs2 = cls inside {OP_ADD, OP_SW};

	assign rs1_ex_hit = src_hit(ex.valid, ex.reg_wen, ex.rd, rs1);
	assign rs2_ex_hit = src_hit(ex.valid, ex.reg_wen, ex.rd, rs2);
	assign rs1_m_hit  = src_hit(m_byp.valid, m_byp.reg_wen, m_byp.rd, rs1);
	assign rs2_m_hit  = src_hit(m_byp.valid, m_byp.reg_wen, m_byp.rd, rs2);
	assign rs1_w_hit  = src_hit(w_byp.valid, w_byp.reg_wen, w_byp.rd, rs1);
	assign rs2_w_hit  = src_hit(w_byp.valid, w_byp.reg_wen, w_byp.rd, rs2);

	// The execute result is not ready yet, and a load in memory has no data until writeback.
	assign stall = need_rs1 & (rs1_ex_hit | (rs1_m_hit & m_byp.is_load)) |
	               need_rs2 & (rs2_ex_hit | (rs2_m_hit & m_byp.is_load));

	assign pop = head_valid & ~stall;

	assign src1 = rs1_m_hit ? m_byp.value : rs1_w_hit ? w_byp.value : rdata1;
	assign src2 = rs2_m_hit ? m_byp.value : rs2_w_hit ? w_byp.value : rdata2;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ex.valid <= 1'b0;
			pc       <= RESET_PC;
		end else begin
			ex.valid <= pop; // execute never stalls, so this empties itself.
			if (pop) begin
				pc <= pc + 32'd4;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			ex.op      <= cls;
			ex.rd      <= rd;
			ex.reg_wen <= reg_wen;
			ex.src1    <= src1;
			ex.src2    <= src2;
			ex.imm     <= imm;
			ex.pc      <= pc;
		end
	end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import core_pkg::*; (
	input  logic              clock,
	input  logic              arst_n,
	input  logic [REG_AW-1:0] rs1,
	input  logic [REG_AW-1:0] rs2,
	output logic [XLEN-1:0]   rdata1,
	output logic [XLEN-1:0]   rdata2,
	bypass_if.sink            wr
);

	logic [XLEN-1:0] regs [1 << REG_AW];

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < (1 << REG_AW); k++) begin
				regs[k] <= '0;
			end
		end else if (wr.valid & wr.reg_wen & (wr.rd != '0)) begin
			regs[wr.rd] <= wr.value; // decode forwards this value in the same cycle.
		end
	end

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit import core_pkg::*; (
	input  logic      clock,
	input  logic      arst_n,
	ex_bus_if.sink    ex,
	mem_bus_if.source mem,
	bypass_if.source  m_byp
);

	logic [XLEN-1:0] result;

	always_comb begin
		case (ex.op)
			OP_LUI:   result = ex.imm;
			OP_AUIPC: result = ex.pc + ex.imm;
			OP_ADD:   result = ex.src1 + ex.src2;
			default:  result = ex.src1 + ex.imm; // addi, and the address of lw and sw.
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			mem.valid <= 1'b0;
		end else begin
			mem.valid <= ex.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (ex.valid) begin
			mem.is_load    <= (ex.op == OP_LW);
			mem.is_store   <= (ex.op == OP_SW);
			mem.rd         <= ex.rd;
			mem.reg_wen    <= ex.reg_wen;
			mem.result     <= result;
			mem.store_data <= ex.src2;
		end
	end

	assign m_byp.valid   = mem.valid;
	assign m_byp.rd      = mem.rd;
	assign m_byp.reg_wen = mem.reg_wen;
	assign m_byp.is_load = mem.is_load;
	assign m_byp.value   = mem.result; // only an address when is_load is set.

endmodule

// ==== verilog/mem_unit.sv ====
`timescale 1ns/1ns

module mem_unit import core_pkg::*; #(
	parameter int DMEM_WORDS = 64
) (
	input  logic              clock,
	input  logic              arst_n,
	mem_bus_if.sink           mem,
	bypass_if.source          w_byp,
	output logic              retire_valid,
	output logic [REG_AW-1:0] retire_rd,
	output logic [XLEN-1:0]   retire_data
);

	localparam int IDX_W = $clog2(DMEM_WORDS);

	logic [XLEN-1:0]  dmem [DMEM_WORDS];
	logic [IDX_W-1:0] idx;

	assign idx = mem.result[IDX_W+1:2]; // word index wraps at the memory size.

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < DMEM_WORDS; k++) begin
				dmem[k] <= '0;
			end
		end else if (mem.valid & mem.is_store) begin
			dmem[idx] <= mem.store_data;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			w_byp.valid <= 1'b0;
		end else begin
			w_byp.valid <= mem.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (mem.valid) begin
			w_byp.rd      <= mem.rd;
			w_byp.reg_wen <= mem.reg_wen;
			w_byp.is_load <= mem.is_load;
			w_byp.value   <= mem.is_load ? dmem[idx] : mem.result;
		end
	end

	// Stores, bubbles and writes to x0 leave no trace on the retire port.
	assign retire_valid = w_byp.valid & w_byp.reg_wen & (w_byp.rd != '0);
	assign retire_rd    = w_byp.rd;
	assign retire_data  = w_byp.value;

endmodule

// ==== verilog/core_top.sv ====
`timescale 1ns/1ns

module core_top import core_pkg::*; #(
	parameter int              QUEUE_DEPTH = 4,
	parameter int              DMEM_WORDS  = 64,
	parameter logic [XLEN-1:0] RESET_PC    = '0
) (
	input  logic              clock,
	input  logic              arst_n,
	input  logic              inst_valid,
	input  logic [31:0]       inst,
	output logic              inst_credit,
	output logic              retire_valid,
	output logic [REG_AW-1:0] retire_rd,
	output logic [XLEN-1:0]   retire_data
);

	logic              head_valid;
	logic [31:0]       head_inst;
	logic              pop;
	logic [REG_AW-1:0] rs1;
	logic [REG_AW-1:0] rs2;
	logic [XLEN-1:0]   rdata1;
	logic [XLEN-1:0]   rdata2;

	ex_bus_if  ex_bus ();
	mem_bus_if mem_bus ();
	bypass_if  m_byp ();
	bypass_if  w_byp ();

	inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (
		.clock(clock),
		.arst_n(arst_n),
		.inst_valid(inst_valid),
		.inst(inst),
		.head_valid(head_valid),
		.head_inst(head_inst),
		.pop(pop),
		.inst_credit(inst_credit)
	);

	decode_stage #(.RESET_PC(RESET_PC)) decode0 (
		.clock(clock),
		.arst_n(arst_n),
		.head_valid(head_valid),
		.head_inst(head_inst),
		.pop(pop),
		.rs1(rs1),
		.rs2(rs2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.ex(ex_bus),
		.m_byp(m_byp),
		.w_byp(w_byp)
	);

	reg_file regs0 (
		.clock(clock),
		.arst_n(arst_n),
		.rs1(rs1),
		.rs2(rs2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.wr(w_byp)
	);

	exec_unit exec0 (
		.clock(clock),
		.arst_n(arst_n),
		.ex(ex_bus),
		.mem(mem_bus),
		.m_byp(m_byp)
	);

	mem_unit #(.DMEM_WORDS(DMEM_WORDS)) mem0 (
		.clock(clock),
		.arst_n(arst_n),
		.mem(mem_bus),
		.w_byp(w_byp),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_data(retire_data)
	);

endmodule

// ==== sim/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam logic [6:0] LUI_OP    = 7'b0110111;
localparam logic [6:0] AUIPC_OP  = 7'b0010111;
localparam logic [6:0] ADDI_OP   = 7'b0010011;
localparam logic [6:0] ADD_OP    = 7'b0110011;
localparam logic [6:0] LW_OP     = 7'b0000011;
localparam logic [6:0] SW_OP     = 7'b0100011;
localparam logic [6:0] BRANCH_OP = 7'b1100011;
localparam logic [6:0] FENCE_OP  = 7'b0001111;

logic [31:0] lcg_state = 32'h49b3;
logic [31:0] prog [N_INST];
logic [31:0] model_regs [16];
logic [31:0] model_mem [DMEM_WORDS];
logic [35:0] exp_q [$]; // {rd, value} in program order.

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
	return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
	return {imm, rs1, (op == LW_OP) ? 3'b010 : 3'b000, rd, op};
endfunction

function automatic logic [31:0] enc_r(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
	return {7'b0, rs2, rs1, 3'b000, rd, ADD_OP};
endfunction

function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [11:0] imm);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], SW_OP};
endfunction

function automatic int word_index(input logic [31:0] addr);
	return int'(addr >> 2) % DMEM_WORDS;
endfunction

function automatic logic [31:0] random_inst();
	logic [31:0] r;
	logic [31:0] r2;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	r   = lcg_next();
	r2  = lcg_next();
	rd  = 5'(r[15:8] % 7); // x7 holds the data base and is never written.
	rs1 = {2'b00, r[18:16]};
	rs2 = {2'b00, r[21:19]};
	case (r[31:28] % 10)
		0:       return enc_u(LUI_OP, rd, r2[19:0]);
		1:       return enc_u(AUIPC_OP, rd, r2[19:0]);
		2, 3:    return enc_i(ADDI_OP, rd, rs1, r2[11:0]);
		4, 5:    return enc_r(rd, rs1, rs2);
		6:       return enc_i(LW_OP, rd, 5'd7, {4'b0, r2[5:0], 2'b00});
		7:       return enc_s(5'd7, rs2, {4'b0, r2[5:0], 2'b00});
		default: return {r2[31:7], BRANCH_OP};
	endcase
endfunction

function automatic void ref_exec(input logic [31:0] w, input logic [31:0] pc);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_i;
	logic [31:0] val;
	logic        wen;
	a     = model_regs[w[18:15]];
	b     = model_regs[w[23:20]];
	imm_i = {{20{w[31]}}, w[31:20]};
	val   = '0;
	wen   = 1'b1;
	case (w[6:0])
		LUI_OP:   val = {w[31:12], 12'b0};
		AUIPC_OP: val = pc + {w[31:12], 12'b0};
		ADDI_OP:  val = a + imm_i;
		ADD_OP:   val = a + b;
		LW_OP:    val = model_mem[word_index(a + imm_i)];
		SW_OP: begin
			wen = 1'b0;
			model_mem[word_index(a + {{20{w[31]}}, w[31:25], w[11:7]})] = b;
		end
		default:  wen = 1'b0;
	endcase
	if (wen && w[11:7] != 5'd0) begin
		model_regs[w[10:7]] = val; // model_regs[0] is never written, so x0 reads zero.
		exp_q.push_back({w[10:7], val});
	end
endfunction

task automatic build_program();
	logic [31:0] pc;
	for (int k = 0; k < 16; k++) model_regs[k] = '0;
	for (int k = 0; k < DMEM_WORDS; k++) model_mem[k] = '0;
	prog[0]  = enc_u(LUI_OP, 5'd7, 20'h00010);
	prog[1]  = enc_u(LUI_OP, 5'd1, 20'h12345);
	prog[2]  = enc_i(ADDI_OP, 5'd1, 5'd1, 12'h678);
	prog[3]  = enc_r(5'd2, 5'd1, 5'd1);
	prog[4]  = enc_u(AUIPC_OP, 5'd3, 20'h00001);
	prog[5]  = enc_i(ADDI_OP, 5'd4, 5'd0, 12'hffb);
	prog[6]  = enc_s(5'd7, 5'd2, 12'd8);
	prog[7]  = enc_i(LW_OP, 5'd5, 5'd7, 12'd8); // reads back the word just stored.
	prog[8]  = enc_r(5'd6, 5'd5, 5'd4); // load-use stall.
	prog[9]  = enc_i(ADDI_OP, 5'd0, 5'd1, 12'h001);
	prog[10] = {25'h0, FENCE_OP};
	prog[11] = enc_r(5'd1, 5'd0, 5'd0);
	for (int k = 12; k < N_INST; k++) prog[k] = random_inst();
	pc = RESET_PC;
	for (int k = 0; k < N_INST; k++) begin
		ref_exec(prog[k], pc);
		pc = pc + 32'd4;
	end
endtask

`endif

// ==== sim/tb_core.sv ====
`timescale 1ns/1ns

module tb_core;

	localparam int          N_INST      = 400;
	localparam int          QUEUE_DEPTH = 4;
	localparam int          DMEM_WORDS  = 64;
	localparam logic [31:0] RESET_PC    = 32'h0000_0200;
	localparam int          CYCLE_LIMIT = N_INST * 8 + 100;

	logic        clock = 1'b0;
	logic        arst_n = 1'b0;
	logic        inst_valid = 1'b0;
	logic [31:0] inst = '0;
	logic        inst_credit;
	logic        retire_valid;
	logic [3:0]  retire_rd;
	logic [31:0] retire_data;

	int          sent = 0;
	int          returned = 0;
	int          cycles = 0;
	logic        sending = 1'b0;
	logic [31:0] gap_rnd;
	logic [35:0] expected;

	`include "tb_model.svh"

	core_top #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.DMEM_WORDS(DMEM_WORDS),
		.RESET_PC(RESET_PC)
	) dut0 (
		.clock(clock),
		.arst_n(arst_n),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_credit(inst_credit),
		.retire_valid(retire_valid),
		.retire_rd(retire_rd),
		.retire_data(retire_data)
	);

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped on the first error");
	endtask

	initial begin
		forever #50 clock = ~clock;
	end

	initial begin
		build_program();
		repeat (8) @(posedge clock);
		arst_n <= 1'b1;
		repeat (4) begin
			@(negedge clock);
			assert (!inst_credit && !retire_valid) else
				stop_with_error("inst_credit or retire_valid went high after reset with no input");
		end
		@(posedge clock);
		sending <= 1'b1;
		while (!(sent == N_INST && returned == N_INST && exp_q.size() == 0)) begin
			@(negedge clock);
		end
		repeat (6) @(negedge clock); // a stray retire after the last expected one still fails here.
		$display("Done: no errors");
		$finish;
	end

	// the sender spends one credit for each cycle with inst_valid high.
	always @(posedge clock) begin
		gap_rnd = lcg_next();
		if (sending && sent < N_INST && (sent - returned) < QUEUE_DEPTH &&
				gap_rnd[30:29] != 2'b00) begin
			inst_valid <= 1'b1;
			inst       <= prog[sent];
			sent       <= sent + 1;
		end else begin
			inst_valid <= 1'b0;
		end
	end

	always @(negedge clock) begin
		if (arst_n) begin
			if (inst_credit) begin
				assert (returned < sent) else
					stop_with_error("inst_credit pulsed with no instruction outstanding");
				returned <= returned + 1;
			end
		end
	end

	always @(negedge clock) begin
		if (arst_n && retire_valid) begin
			assert (exp_q.size() != 0) else
				stop_with_error("the core retired a result that the program never produces");
			expected = exp_q.pop_front();
			assert (retire_rd == expected[35:32] && retire_data == expected[31:0]) else
				stop_with_error($sformatf(
					"CHECK FAILED at %0t: retired x%0d = %08h, expected x%0d = %08h",
					$time, retire_rd, retire_data, expected[35:32], expected[31:0]));
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			stop_with_error($sformatf("the run timed out after %0d cycles", cycles));
		end
	end

endmodule

// ==== all.f ====
+incdir+sim
verilog/core_pkg.sv
verilog/pipe_ifs.sv
verilog/inst_queue.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/mem_unit.sv
verilog/core_top.sv
sim/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' all.f) sim/tb_model.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): all.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f all.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
